// ==== bench/emu_ctrl_asserts.sv ====
`timescale 1ns/10ps

module emu_ctrl_asserts (
    input logic clk,
    input logic rst,
    input logic cmd_full,
    input logic cmd_rempty,
    input logic resp_winc,
    input logic resp_wfull,
    input logic resp_empty
);

    int unsigned fail_cnt = 0;      // Watched by the testbench

    // Room is reserved before a pop, so a push never meets a full FIFO
    no_resp_overflow: assert property (@(posedge clk) disable iff (rst)
        !(resp_winc && resp_wfull))
        else begin
            $error("response FIFO pushed while full");
            fail_cnt++;
        end

    cmd_flags_apart: assert property (@(posedge clk) disable iff (rst)
        !(cmd_full && cmd_rempty))
        else begin
            $error("command FIFO full and empty together");
            fail_cnt++;
        end

    resp_flags_apart: assert property (@(posedge clk) disable iff (rst)
        !(resp_wfull && resp_empty))
        else begin
            $error("response FIFO full and empty together");
            fail_cnt++;
        end

    reset_flags: assert property (@(posedge clk) rst |=> (!cmd_full && resp_empty))
        else begin
            $error("FIFO flags wrong after reset");
            fail_cnt++;
        end

    first_resp_visible: assert property (@(posedge clk) disable iff (rst)
        (resp_winc && resp_empty) |=> !resp_empty)
        else begin
            $error("push into empty response FIFO not visible");
            fail_cnt++;
        end

endmodule

bind emu_ctrl_top emu_ctrl_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .cmd_full   (cmd_full),
    .cmd_rempty (cmd_rempty),
    .resp_winc  (resp_winc),
    .resp_wfull (resp_wfull),
    .resp_empty (resp_empty)
);

// ==== bench/emu_ctrl_tb.sv ====
`timescale 1ns/10ps

module emu_ctrl_tb;

    localparam int num_regs   = 12;
    localparam int cmd_depth  = 8;
    localparam int resp_depth = 8;
    localparam int wait_limit = 200;

    logic                clk;
    logic                rst;
    logic                cmd_push;
    logic                cmd_full;
    emu_ctrl_pkg::cmd_t  cmd_in;
    logic                resp_pop;
    logic                resp_empty;
    emu_ctrl_pkg::resp_t resp_out;

    logic [31:0]         model_regs [num_regs];
    emu_ctrl_pkg::resp_t exp_q [$];

    emu_ctrl_top #(
        .num_regs   (num_regs),
        .cmd_depth  (cmd_depth),
        .resp_depth (resp_depth)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .cmd_push   (cmd_push),
        .cmd_full   (cmd_full),
        .cmd_in     (cmd_in),
        .resp_pop   (resp_pop),
        .resp_empty (resp_empty),
        .resp_out   (resp_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Bound assertions count their failures
    always @(negedge clk) begin
        if (dut.u_asserts.fail_cnt != 0) begin
            $display("A bound assertion on the DUT failed");
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    task automatic fail_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        $display("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic fail_text(input string what);
        $display("Error at %0t: %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    function automatic emu_ctrl_pkg::cmd_t make_cmd(emu_ctrl_pkg::op_e op, int addr,
                                                    logic [31:0] data);
        emu_ctrl_pkg::cmd_t c;
        c.op   = op;
        c.addr = addr[emu_ctrl_pkg::addr_w-1:0];
        c.data = data;
        return c;
    endfunction

    function automatic emu_ctrl_pkg::cmd_t rand_cmd();
        emu_ctrl_pkg::cmd_t c;
        int unsigned        r;
        r      = $urandom();
        c.op   = emu_ctrl_pkg::op_e'(r[5:4]);
        c.addr = r[emu_ctrl_pkg::addr_w-1:0];     // 12 to 15 are out of range
        c.data = $urandom();
        return c;
    endfunction

    // Expected response from the register rules in command order
    task automatic model_command(input emu_ctrl_pkg::cmd_t c);
        emu_ctrl_pkg::resp_t r;
        r.op   = c.op;
        r.addr = c.addr;
        r.err  = 1'b0;
        r.data = '0;
        if (int'(c.addr) >= num_regs || c.op == emu_ctrl_pkg::op_nop) begin
            r.err = 1'b1;
        end else begin
            case (c.op)
                emu_ctrl_pkg::op_write: model_regs[c.addr] = c.data;
                emu_ctrl_pkg::op_add:   model_regs[c.addr] = model_regs[c.addr] + c.data;
                default: ;
            endcase
            r.data = model_regs[c.addr];
        end
        exp_q.push_back(r);
    endtask

    // ========================================================================
    // One clock cycle entered and left 1 ns after a rising edge
    // ========================================================================

    task automatic step(input logic push, input emu_ctrl_pkg::cmd_t c, input logic pop,
                        output logic pushed, output logic popped);
        emu_ctrl_pkg::resp_t exp;
        cmd_push = push;
        cmd_in   = c;
        resp_pop = pop;
        pushed   = push && !cmd_full;
        popped   = pop && !resp_empty;
        if (pushed)
            model_command(c);
        @(posedge clk);
        #1;
        if (popped) begin
            assert (exp_q.size() != 0)
                else fail_text("response popped with no command outstanding");
            exp = exp_q.pop_front();
            assert (resp_out === exp) else fail_value("resp_out", resp_out, exp);
        end
    endtask

    task automatic send(input emu_ctrl_pkg::cmd_t c);
        logic pushed;
        logic popped;
        int   waited;
        pushed = 1'b0;
        waited = 0;
        while (!pushed) begin
            step(1'b1, c, 1'b1, pushed, popped);
            waited++;
            if (!pushed && waited >= wait_limit)
                fail_text("command push not accepted within 200 cycles");
        end
    endtask

    task automatic drain();
        logic pushed;
        logic popped;
        int   idle;
        idle = 0;
        while (exp_q.size() != 0) begin
            step(1'b0, '0, 1'b1, pushed, popped);
            idle = popped ? 0 : idle + 1;
            if (idle >= wait_limit)
                fail_text("expected responses still missing after 200 idle cycles");
        end
        step(1'b0, '0, 1'b0, pushed, popped);
        assert (resp_empty === 1'b1) else fail_value("resp_empty", resp_empty, 1'b1);
    endtask

    task automatic read_all();
        for (int i = 0; i < num_regs; i++)
            send(make_cmd(emu_ctrl_pkg::op_read, i, '0));
        drain();
    endtask

    initial begin
        emu_ctrl_pkg::cmd_t c;
        logic               pushed;
        logic               popped;
        int                 n;
        int                 idle;
        int                 waited;

        void'($urandom(37));
        rst      = 1'b1;
        cmd_push = 1'b0;
        cmd_in   = '0;
        resp_pop = 1'b0;
        foreach (model_regs[i])
            model_regs[i] = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset state
        assert (cmd_full === 1'b0) else fail_value("cmd_full", cmd_full, 1'b0);
        assert (resp_empty === 1'b1) else fail_value("resp_empty", resp_empty, 1'b1);
        read_all();

        // Write then read back
        for (int i = 0; i < num_regs; i++)
            send(make_cmd(emu_ctrl_pkg::op_write, i, 32'hA5C3_0000 ^ (i * 32'h0101_0111)));
        read_all();

        // Running sums through 2^32
        send(make_cmd(emu_ctrl_pkg::op_write, 7, 32'hFFFF_FF00));
        repeat (5) send(make_cmd(emu_ctrl_pkg::op_add, 7, 32'h0000_0040));
        repeat (3) send(make_cmd(emu_ctrl_pkg::op_add, 7, 32'h8000_0001));
        drain();

        // Bad address and reserved opcode leave the bank alone
        send(make_cmd(emu_ctrl_pkg::op_write, 12, 32'h1234_5678));
        send(make_cmd(emu_ctrl_pkg::op_add, 15, 32'h0000_0001));
        send(make_cmd(emu_ctrl_pkg::op_read, 13, '0));
        send(make_cmd(emu_ctrl_pkg::op_nop, 3, 32'hDEAD_BEEF));
        drain();
        read_all();

        // ====================================================================
        // Back-pressure with the host not popping
        // ====================================================================

        n      = 0;
        waited = 0;
        while (!cmd_full) begin
            step(1'b1, rand_cmd(), 1'b0, pushed, popped);
            n = pushed ? n + 1 : n;
            waited++;
            if (waited >= wait_limit)
                fail_text("cmd_full never seen while the host was not popping");
        end
        assert (n == cmd_depth + resp_depth)
            else fail_value("accepted pushes", n, cmd_depth + resp_depth);
        for (int i = n; i < 30; i++)
            send(rand_cmd());
        drain();

        // Random stream
        n    = 0;
        idle = 0;
        while (n < 300) begin
            c = rand_cmd();
            step($urandom_range(0, 3) != 0, c, $urandom_range(0, 1) != 0, pushed, popped);
            n    = pushed ? n + 1 : n;
            idle = (pushed || popped) ? 0 : idle + 1;
            if (idle >= wait_limit)
                fail_text("random stream made no progress for 200 cycles");
        end
        drain();

        if (exp_q.size() == 0 && resp_empty === 1'b1) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("Responses outstanding at the end of the run");
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

// ==== hw/cmd_decode.sv ====
`timescale 1ns/10ps

module cmd_decode #(
    parameter int num_regs = 12
) (
    input  logic               clk,
    input  logic               rst,

    // Command FIFO read side
    input  logic               fifo_empty,
    input  emu_ctrl_pkg::cmd_t fifo_data,
    output logic               fifo_rinc,

    // Credit from the response side
    input  logic               room,
    output logic               issue,

    output emu_ctrl_pkg::dec_t dec
);

    logic popped;
    logic bad_addr;
    logic bad_op;

    // Pop only with a free response slot reserved
    assign fifo_rinc = !fifo_empty && room;
    assign issue     = fifo_rinc;

    assign bad_addr = int'(fifo_data.addr) >= num_regs;
    assign bad_op   = fifo_data.op == emu_ctrl_pkg::op_nop;

    always_ff @(posedge clk) begin
        if (rst)
            popped <= 1'b0;
        else
            popped <= fifo_rinc;    // rdata lands one cycle later
    end

    // ========================================================================
    // Decoded operation register
    // ========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= popped;
            dec.op    <= fifo_data.op;
            dec.addr  <= fifo_data.addr;
            dec.data  <= fifo_data.data;
            dec.bad   <= bad_addr || bad_op;
        end
    end

endmodule

// ==== hw/emu_ctrl_pkg.sv ====
package emu_ctrl_pkg;

    // ========================================================================
    // Widths
    // ========================================================================

    localparam int addr_w = 4;      // Up to 16 registers
    localparam int data_w = 32;

    // ========================================================================
    // Command channel types
    // ========================================================================

    typedef enum logic [1:0] {
        op_read  = 2'd0,
        op_write = 2'd1,
        op_add   = 2'd2,
        op_nop   = 2'd3             // Reserved, answered with err
    } op_e;

    // Host command word, carried by the command FIFO
    typedef struct packed {
        op_e               op;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } cmd_t;

    // Decoded operation, decode to execute
    typedef struct packed {
        logic              valid;
        op_e               op;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic              bad;     // Out of range address or reserved opcode
    } dec_t;

    // Response word, carried by the response FIFO
    typedef struct packed {
        op_e               op;
        logic [addr_w-1:0] addr;
        logic              err;
        logic [data_w-1:0] data;
    } resp_t;

endpackage

// ==== hw/emu_ctrl_top.sv ====
`timescale 1ns/10ps

module emu_ctrl_top #(
    parameter int num_regs   = 12,
    parameter int cmd_depth  = 8,
    parameter int resp_depth = 8
) (
    input  logic                clk,
    input  logic                rst,

    // Host command side
    input  logic                cmd_push,
    output logic                cmd_full,
    input  emu_ctrl_pkg::cmd_t  cmd_in,

    // Host response side
    input  logic                resp_pop,
    output logic                resp_empty,
    output emu_ctrl_pkg::resp_t resp_out
);

    logic                                cmd_rinc;
    logic                                cmd_rempty;
    emu_ctrl_pkg::cmd_t                  cmd_rdata;

    logic                                issue;
    logic                                room;
    emu_ctrl_pkg::dec_t                  dec;
    emu_ctrl_pkg::resp_t                 res;
    logic                                res_valid;

    logic                                resp_winc;
    logic                                resp_wfull;
    emu_ctrl_pkg::resp_t                 resp_wdata;
    logic [$clog2(resp_depth+1)-1:0]     resp_level;

    // ========================================================================
    // Command path
    // ========================================================================

    emulib_fifo #(
        .payload_t (emu_ctrl_pkg::cmd_t),
        .depth     (cmd_depth)
    ) u_cmd_fifo (
        .clk    (clk),
        .rst    (rst),
        .winc   (cmd_push),
        .wfull  (cmd_full),
        .wdata  (cmd_in),
        .rinc   (cmd_rinc),
        .rempty (cmd_rempty),
        .rdata  (cmd_rdata),
        .level  ()
    );

    cmd_decode #(
        .num_regs (num_regs)
    ) u_decode (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (cmd_rempty),
        .fifo_data  (cmd_rdata),
        .fifo_rinc  (cmd_rinc),
        .room       (room),
        .issue      (issue),
        .dec        (dec)
    );

    reg_execute #(
        .num_regs (num_regs)
    ) u_execute (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .res       (res),
        .res_valid (res_valid)
    );

    // ========================================================================
    // Response path
    // ========================================================================

    resp_format #(
        .resp_depth (resp_depth)
    ) u_format (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .res        (res),
        .res_valid  (res_valid),
        .fifo_level (resp_level),
        .fifo_winc  (resp_winc),
        .fifo_wdata (resp_wdata),
        .room       (room)
    );

    emulib_fifo #(
        .payload_t (emu_ctrl_pkg::resp_t),
        .depth     (resp_depth)
    ) u_resp_fifo (
        .clk    (clk),
        .rst    (rst),
        .winc   (resp_winc),
        .wfull  (resp_wfull),
        .wdata  (resp_wdata),
        .rinc   (resp_pop),
        .rempty (resp_empty),
        .rdata  (resp_out),
        .level  (resp_level)
    );

endmodule

// ==== hw/emulib_fifo.sv ====
`timescale 1ns/10ps

module emulib_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 8
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       winc,
    output logic                       wfull,
    input  payload_t                   wdata,

    input  logic                       rinc,
    output logic                       rempty,
    output payload_t                   rdata,

    output logic [$clog2(depth+1)-1:0] level
);

    localparam int ptr_w = $clog2(depth);
    localparam int lvl_w = $clog2(depth + 1);
    localparam logic [ptr_w-1:0] ptr_max = ptr_w'(depth - 1);

    payload_t mem [depth];

    logic [ptr_w-1:0] wp;
    logic [ptr_w-1:0] rp;
    logic [ptr_w-1:0] wp_inc;
    logic [ptr_w-1:0] rp_inc;
    logic             wfire;
    logic             rfire;

    assign wfire  = winc && !wfull;
    assign rfire  = rinc && !rempty;
    assign wp_inc = (wp == ptr_max) ? '0 : wp + 1'b1;     // Wrap at depth
    assign rp_inc = (rp == ptr_max) ? '0 : rp + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            wp     <= '0;
            rp     <= '0;
            wfull  <= 1'b0;
            rempty <= 1'b1;
        end else begin
            if (wfire)
                wp <= wp_inc;
            if (rfire)
                rp <= rp_inc;

            if (rfire)
                wfull <= 1'b0;
            else if (wfire && wp_inc == rp)
                wfull <= 1'b1;

            if (wfire)
                rempty <= 1'b0;
            else if (rfire && rp_inc == wp)
                rempty <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wfire)
            mem[wp] <= wdata;
        if (rfire)
            rdata <= mem[rp];       // Valid the cycle after the pop
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            level <= '0;
        end else begin
            case ({wfire, rfire})
                2'b10:   level <= level + lvl_w'(1);
                2'b01:   level <= level - lvl_w'(1);
                default: level <= level;    // Both or neither
            endcase
        end
    end

endmodule

// ==== hw/reg_execute.sv ====
`timescale 1ns/10ps

module reg_execute #(
    parameter int num_regs = 12
) (
    input  logic                clk,
    input  logic                rst,
    input  emu_ctrl_pkg::dec_t  dec,
    output emu_ctrl_pkg::resp_t res,
    output logic                res_valid
);

    logic [emu_ctrl_pkg::data_w-1:0] regs [num_regs];
    logic [emu_ctrl_pkg::data_w-1:0] cur;
    logic [emu_ctrl_pkg::data_w-1:0] result;
    logic                            wr_en;

    // Current value, only indexed for an in-range address
    always_comb begin
        cur = '0;
        if (!dec.bad)
            cur = regs[dec.addr];
    end

    always_comb begin
        result = cur;
        wr_en  = 1'b0;
        case (dec.op)
            emu_ctrl_pkg::op_write: begin
                result = dec.data;
                wr_en  = dec.valid && !dec.bad;
            end
            emu_ctrl_pkg::op_add: begin
                result = cur + dec.data;    // Wraps modulo 2^32
                wr_en  = dec.valid && !dec.bad;
            end
            default: begin
                result = cur;               // Read, or reserved
            end
        endcase
    end

    // ========================================================================
    // Register bank
    // ========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[dec.addr] <= result;
        end
    end

    // Response fields
    always_ff @(posedge clk) begin
        if (dec.valid) begin
            res.op   <= dec.op;
            res.addr <= dec.addr;
            res.err  <= dec.bad;
            res.data <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            res_valid <= 1'b0;
        else
            res_valid <= dec.valid;
    end

endmodule

// ==== hw/resp_format.sv ====
`timescale 1ns/10ps

module resp_format #(
    parameter int resp_depth = 8
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                issue,

    input  emu_ctrl_pkg::resp_t                 res,
    input  logic                                res_valid,

    // Response FIFO write side
    input  logic [$clog2(resp_depth+1)-1:0]     fifo_level,
    output logic                                fifo_winc,
    output emu_ctrl_pkg::resp_t                 fifo_wdata,

    output logic                                room
);

    localparam int cnt_w = $clog2(resp_depth + 1);

    logic [cnt_w-1:0] in_flight;    // Popped, not yet in the response FIFO

    assign fifo_winc = res_valid;

    // An error response never carries data
    always_comb begin
        fifo_wdata = res;
        if (res.err)
            fifo_wdata.data = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            case ({issue, fifo_winc})
                2'b10:   in_flight <= in_flight + cnt_w'(1);
                2'b01:   in_flight <= in_flight - cnt_w'(1);
                default: in_flight <= in_flight;
            endcase
        end
    end

    // Every command in flight holds a reserved slot
    assign room = (int'(fifo_level) + int'(in_flight)) < resp_depth;

endmodule

// ==== list.f ====
hw/emu_ctrl_pkg.sv
hw/emulib_fifo.sv
hw/cmd_decode.sv
hw/reg_execute.sv
hw/resp_format.sv
hw/emu_ctrl_top.sv
bench/emu_ctrl_asserts.sv
bench/emu_ctrl_tb.sv
